// File: Bender.yml
package:
  name: corr_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/corr_cmd_pkg.sv
      - src/corr_uart_rx.sv
      - src/corr_cmd_parser.sv
      - src/corr_ctrl_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/corr_ctrl_sva.sv
      - verification/corr_ctrl_tb.sv

// File: corr_ctrl_top.f
+incdir+src
src/corr_cmd_pkg.sv
src/corr_uart_rx.sv
src/corr_cmd_parser.sv
src/corr_ctrl_top.sv
verification/corr_ctrl_sva.sv
verification/corr_ctrl_tb.sv

// File: src/corr_cmd_defs.svh
// line width must hold the line count and the delay width must be a whole number of nibbles.
`ifndef CORR_CMD_DEFS_SVH
`define CORR_CMD_DEFS_SVH

// ####################
// register bank geometry.
// ####################
`define CORR_NUM_LINES 4
`define CORR_LINE_W 2
`define CORR_DELAY_W 16

// bit period is CORR_BAUD_UNIT * (baud_rate + 1) clock cycles.
`define CORR_BAUD_UNIT 4

// ####################
// delay field reset values.
// ####################
`define CORR_CROSS_INC_RST 1
`define CORR_CROSS_LEN_RST 1023
`define CORR_AUTO_INC_RST 1
`define CORR_AUTO_LEN_RST 1

`endif

// File: src/corr_cmd_parser.sv
// one command per byte_valid strobe, no back-pressure; delay fields load a nibble at a time.
`default_nettype none

`include "corr_cmd_defs.svh"

module corr_cmd_parser
	import corr_cmd_pkg::*;
(
	input  logic                                       clk,
	input  logic                                       arst_n,
	input  logic [7:0]                                 byte_data,
	input  logic                                       byte_valid,
	output logic [`CORR_NUM_LINES*8-1:0]               voltage,
	output logic [`CORR_NUM_LINES*8-1:0]               test,
	output logic [`CORR_NUM_LINES*8-1:0]               leds,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_start,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_increment,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_length,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_start,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_increment,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_length,
	output logic [`CORR_LINE_W-1:0]                    current_line,
	output logic [3:0]                                 baud_rate,
	output logic                                       integrating,
	output logic                                       external_clock,
	output logic                                       timestamp_reset,
	output logic                                       extended
);

	localparam logic [`CORR_DELAY_W-1:0] cross_inc_rst = `CORR_CROSS_INC_RST;
	localparam logic [`CORR_DELAY_W-1:0] cross_len_rst = `CORR_CROSS_LEN_RST;
	localparam logic [`CORR_DELAY_W-1:0] auto_inc_rst  = `CORR_AUTO_INC_RST;
	localparam logic [`CORR_DELAY_W-1:0] auto_len_rst  = `CORR_AUTO_LEN_RST;

	corr_opcode_e              opcode;
	logic [3:0]                nibble;
	logic [`CORR_LINE_W+3:0]   line_shift;
	int                        line_mod;
	int                        byte_base;
	int                        dly_base;

	function automatic logic [`CORR_DELAY_W-1:0] shift_in(
		input logic [`CORR_DELAY_W-1:0] field,
		input logic [3:0]               nib
	);
		return {field[`CORR_DELAY_W-5:0], nib};
	endfunction

	assign opcode     = corr_opcode_e'(byte_data[3:0]);
	assign nibble     = byte_data[7:4];
	assign line_shift = {current_line, nibble};
	assign line_mod   = int'(line_shift) % `CORR_NUM_LINES;

	// the extended flag picks the high nibble of a byte.
	assign byte_base = int'(current_line) * 8 + (extended ? 4 : 0);
	assign dly_base  = int'(current_line) * `CORR_DELAY_W;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			voltage         <= '0;
			test            <= '0;
			leds            <= '0;
			cross_start     <= '0;
			cross_increment <= {`CORR_NUM_LINES{cross_inc_rst}};
			cross_length    <= {`CORR_NUM_LINES{cross_len_rst}};
			auto_start      <= '0;
			auto_increment  <= {`CORR_NUM_LINES{auto_inc_rst}};
			auto_length     <= {`CORR_NUM_LINES{auto_len_rst}};
			current_line    <= '0;
			baud_rate       <= '0;
			integrating     <= 1'b0;
			external_clock  <= 1'b0;
			timestamp_reset <= 1'b1;
			extended        <= 1'b0;
		end else if (byte_valid) begin
			case (opcode)
				clear: begin
					voltage         <= '0;
					test            <= '0;
					leds            <= '0;
					cross_start     <= '0;
					cross_increment <= {`CORR_NUM_LINES{cross_inc_rst}};
					cross_length    <= {`CORR_NUM_LINES{cross_len_rst}};
					auto_start      <= '0;
					auto_increment  <= {`CORR_NUM_LINES{auto_inc_rst}};
					auto_length     <= {`CORR_NUM_LINES{auto_len_rst}};
					current_line    <= '0;
					baud_rate       <= '0;
					integrating     <= 1'b0;
					external_clock  <= 1'b0;
					timestamp_reset <= 1'b1;
					extended        <= 1'b0;
				end
				set_line: current_line <= line_mod[`CORR_LINE_W-1:0];
				set_leds: leds[byte_base +: 4] <= nibble;
				set_baud: baud_rate <= nibble;
				set_voltage: voltage[byte_base +: 4] <= nibble;
				enable_test: test[byte_base +: 4] <= nibble;

				// ####################
				// delay fields with the bank chosen by the extended flag.
				// ####################
				delay_start: begin
					if (extended) begin
						auto_start[dly_base +: `CORR_DELAY_W] <=
							shift_in(auto_start[dly_base +: `CORR_DELAY_W], nibble);
					end else begin
						cross_start[dly_base +: `CORR_DELAY_W] <=
							shift_in(cross_start[dly_base +: `CORR_DELAY_W], nibble);
					end
				end
				delay_increment: begin
					if (extended) begin
						auto_increment[dly_base +: `CORR_DELAY_W] <=
							shift_in(auto_increment[dly_base +: `CORR_DELAY_W], nibble);
					end else begin
						cross_increment[dly_base +: `CORR_DELAY_W] <=
							shift_in(cross_increment[dly_base +: `CORR_DELAY_W], nibble);
					end
				end
				delay_length: begin
					if (extended) begin
						auto_length[dly_base +: `CORR_DELAY_W] <=
							shift_in(auto_length[dly_base +: `CORR_DELAY_W], nibble);
					end else begin
						cross_length[dly_base +: `CORR_DELAY_W] <=
							shift_in(cross_length[dly_base +: `CORR_DELAY_W], nibble);
					end
				end

				enable_capture: begin
					integrating     <= byte_data[4];
					external_clock  <= byte_data[5];
					timestamp_reset <= byte_data[6];
					extended        <= byte_data[7];
				end
				// unused opcodes fall through untouched.
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/corr_cmd_pkg.sv
// opcode values are fixed by the host protocol and unlisted opcodes are ignored by the parser.
`default_nettype none

package corr_cmd_pkg;

	// low nibble of a command byte.
	typedef enum logic [3:0] {
		clear           = 4'd0,
		set_line        = 4'd1,
		set_leds        = 4'd2,
		set_baud        = 4'd3,
		set_voltage     = 4'd4,
		delay_start     = 4'd8,
		delay_increment = 4'd9,
		delay_length    = 4'd10,
		enable_test     = 4'd12,
		enable_capture  = 4'd13
	} corr_opcode_e;

	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} rx_state_e;

endpackage

`default_nettype wire

// File: src/corr_ctrl_top.sv
// baud_rate loops back through the parser, so a new rate applies from the next frame on.
`default_nettype none

`include "corr_cmd_defs.svh"

module corr_ctrl_top (
	input  logic                                       clk,
	input  logic                                       arst_n,
	input  logic                                       rxd,
	output logic                                       frame_error,
	output logic [`CORR_NUM_LINES*8-1:0]               voltage,
	output logic [`CORR_NUM_LINES*8-1:0]               test,
	output logic [`CORR_NUM_LINES*8-1:0]               leds,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_start,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_increment,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   cross_length,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_start,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_increment,
	output logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0]   auto_length,
	output logic [`CORR_LINE_W-1:0]                    current_line,
	output logic [3:0]                                 baud_rate,
	output logic                                       integrating,
	output logic                                       external_clock,
	output logic                                       timestamp_reset,
	output logic                                       extended
);

	logic [7:0] byte_data;
	logic       byte_valid;

	corr_uart_rx rx_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.rxd         (rxd),
		.baud_rate   (baud_rate),
		.byte_data   (byte_data),
		.byte_valid  (byte_valid),
		.frame_error (frame_error)
	);

	corr_cmd_parser parser_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.byte_data       (byte_data),
		.byte_valid      (byte_valid),
		.voltage         (voltage),
		.test            (test),
		.leds            (leds),
		.cross_start     (cross_start),
		.cross_increment (cross_increment),
		.cross_length    (cross_length),
		.auto_start      (auto_start),
		.auto_increment  (auto_increment),
		.auto_length     (auto_length),
		.current_line    (current_line),
		.baud_rate       (baud_rate),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.extended        (extended)
	);

endmodule

`default_nettype wire

// File: src/corr_uart_rx.sv
// 8N1 only, no glitch filter on rxd; baud_rate is taken at each start edge, not mid-frame.
`default_nettype none

`include "corr_cmd_defs.svh"

module corr_uart_rx
	import corr_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rxd,
	input  logic [3:0] baud_rate,
	output logic [7:0] byte_data,
	output logic       byte_valid,
	output logic       frame_error
);

	localparam int cnt_w = $clog2(`CORR_BAUD_UNIT * 16 + 1);

	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_last;
	rx_state_e        state;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] bit_period;
	logic [cnt_w-1:0] new_period;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;

	assign new_period = cnt_w'(`CORR_BAUD_UNIT * (int'(baud_rate) + 1));
	assign byte_data  = shift_reg;

	// two-flop synchronizer and one more stage for the falling edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	// ####################
	// frame FSM.
	// ####################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= idle;
			cnt         <= '0;
			bit_period  <= '0;
			bit_idx     <= '0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
			case (state)
				idle: begin
					// first check lands in the middle of the start bit.
					if (rxd_last && !rxd_sync) begin
						bit_period <= new_period;
						cnt        <= (new_period >> 1) - 1'b1;
						state      <= start;
					end
				end
				start: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (rxd_sync) begin
						state <= idle;
					end else begin
						cnt     <= bit_period - 1'b1;
						bit_idx <= '0;
						state   <= data;
					end
				end
				data: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= bit_period - 1'b1;
						if (bit_idx == 3'd7) begin
							state <= stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				stop: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						byte_valid  <= rxd_sync;
						frame_error <= !rxd_sync;
						state       <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// lsb first, so each sample enters at the top.
	always_ff @(posedge clk) begin
		if (state == data && cnt == '0) begin
			shift_reg <= {rxd_sync, shift_reg[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: verification/corr_ctrl_sva.sv
// bound into every corr_cmd_parser; the checks hold only while arst_n is high.
`default_nettype none

`include "corr_cmd_defs.svh"

module corr_ctrl_sva
	import corr_cmd_pkg::*;
(
	input logic                                     clk,
	input logic                                     arst_n,
	input logic [7:0]                               byte_data,
	input logic                                     byte_valid,
	input logic [`CORR_NUM_LINES*8-1:0]             voltage, test, leds,
	input logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0] cross_start, cross_increment, cross_length,
	input logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0] auto_start, auto_increment, auto_length,
	input logic [`CORR_LINE_W-1:0]                  current_line,
	input logic [3:0]                               baud_rate,
	input logic                                     integrating, external_clock,
	input logic                                     timestamp_reset, extended
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [`CORR_DELAY_W-1:0] c_inc = `CORR_CROSS_INC_RST;
	localparam logic [`CORR_DELAY_W-1:0] c_len = `CORR_CROSS_LEN_RST;
	localparam logic [`CORR_DELAY_W-1:0] a_inc = `CORR_AUTO_INC_RST;
	localparam logic [`CORR_DELAY_W-1:0] a_len = `CORR_AUTO_LEN_RST;

	logic [489:0] regs;
	logic [489:0] rst_regs;

	assign regs = {voltage, test, leds, cross_start, cross_increment, cross_length,
		auto_start, auto_increment, auto_length, current_line, baud_rate,
		integrating, external_clock, timestamp_reset, extended};
	assign rst_regs = {96'b0, 64'b0, {`CORR_NUM_LINES{c_inc}}, {`CORR_NUM_LINES{c_len}},
		64'b0, {`CORR_NUM_LINES{a_inc}}, {`CORR_NUM_LINES{a_len}}, 6'b0, 4'b0010};

	hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		!byte_valid |=> $stable(regs))
		else $error("parser registers changed without a byte strobe");

	clear_a: assert property (@(posedge clk) disable iff (!arst_n)
		byte_valid && byte_data[3:0] == clear |=> regs == rst_regs)
		else $error("clear did not restore the reset values");

	// clear also returns baud_rate to zero.
	baud_a: assert property (@(posedge clk) disable iff (!arst_n)
		!$stable(baud_rate) |-> $past(byte_valid) &&
			($past(byte_data[3:0]) == set_baud || $past(byte_data[3:0]) == clear))
		else $error("baud_rate changed without a set_baud or clear strobe");

endmodule

bind corr_cmd_parser corr_ctrl_sva sva_i (.*);

`default_nettype wire

// File: verification/corr_ctrl_tb.sv
// watches the internal byte strobe of dut_i; set_baud selectors above 3 are never sent.
`default_nettype none

`include "corr_cmd_defs.svh"

module corr_ctrl_tb
	import corr_cmd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// 300 frames of 12 bit periods at selector 3, plus margin.
	localparam int max_cycles = 300 * 12 * `CORR_BAUD_UNIT * 4 + 5000;

	logic clk, arst_n, rxd, frame_error;
	logic [`CORR_NUM_LINES*8-1:0] voltage, test, leds;
	logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0] cross_start, cross_increment, cross_length;
	logic [`CORR_NUM_LINES*`CORR_DELAY_W-1:0] auto_start, auto_increment, auto_length;
	logic [`CORR_LINE_W-1:0] current_line;
	logic [3:0] baud_rate;
	logic integrating, external_clock, timestamp_reset, extended;

	logic [31:0] lfsr;
	int          cycles, bv_count, fe_count, mismatches, failures;

	// model delay index is bank * 3 + kind (start, increment, length).
	logic [7:0]  m_volt [`CORR_NUM_LINES];
	logic [7:0]  m_test [`CORR_NUM_LINES];
	logic [7:0]  m_leds [`CORR_NUM_LINES];
	logic [15:0] m_dly [6][`CORR_NUM_LINES];
	int          m_line, m_baud;
	logic        m_int, m_xclk, m_ts, m_ext;

	corr_ctrl_top dut_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (dut_i.byte_valid) bv_count++;
		if (frame_error) fe_count++;
		if (cycles == max_cycles) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// ####################
	// random numbers.
	// ####################
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [3:0] pick_op(input int mode, input logic [3:0] r);
		if (mode == 2) return r;
		case (r % 5)
			0: return (mode == 0) ? set_line : delay_start;
			1: return (mode == 0) ? set_voltage : delay_increment;
			2: return (mode == 0) ? enable_test : delay_length;
			3: return (mode == 0) ? set_leds : set_line;
			default: return enable_capture;
		endcase
	endfunction

	// ####################
	// reference model.
	// ####################
	task automatic model_reset();
		for (int i = 0; i < `CORR_NUM_LINES; i++) begin
			m_volt[i] = '0;
			m_test[i] = '0;
			m_leds[i] = '0;
			m_dly[0][i] = '0;
			m_dly[1][i] = `CORR_CROSS_INC_RST;
			m_dly[2][i] = `CORR_CROSS_LEN_RST;
			m_dly[3][i] = '0;
			m_dly[4][i] = `CORR_AUTO_INC_RST;
			m_dly[5][i] = `CORR_AUTO_LEN_RST;
		end
		m_line = 0;
		m_baud = 0;
		{m_int, m_xclk, m_ts, m_ext} = 4'b0010;
	endtask

	task automatic model_apply(input logic [7:0] b);
		logic [3:0] nib;
		int         sh, k;
		nib = b[7:4];
		sh = m_ext ? 4 : 0;
		k = (m_ext ? 3 : 0) + int'(b[3:0]) - 8;
		case (b[3:0])
			clear: model_reset();
			set_line: m_line = ((m_line << 4) | nib) % `CORR_NUM_LINES;
			set_leds: m_leds[m_line][sh +: 4] = nib;
			set_baud: m_baud = nib;
			set_voltage: m_volt[m_line][sh +: 4] = nib;
			enable_test: m_test[m_line][sh +: 4] = nib;
			delay_start, delay_increment, delay_length:
				m_dly[k][m_line] = {m_dly[k][m_line][11:0], nib};
			enable_capture: {m_ext, m_ts, m_xclk, m_int} = nib;
			default: ;
		endcase
	endtask

	task automatic check_value(input string name, input int idx, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s[%0d] is %h, expected %h", $time, name, idx, got, exp);
		end
	endtask

	task automatic check_all();
		for (int i = 0; i < `CORR_NUM_LINES; i++) begin
			check_value("voltage", i, voltage[i*8 +: 8], m_volt[i]);
			check_value("test", i, test[i*8 +: 8], m_test[i]);
			check_value("leds", i, leds[i*8 +: 8], m_leds[i]);
			check_value("cross_start", i, cross_start[i*16 +: 16], m_dly[0][i]);
			check_value("cross_increment", i, cross_increment[i*16 +: 16], m_dly[1][i]);
			check_value("cross_length", i, cross_length[i*16 +: 16], m_dly[2][i]);
			check_value("auto_start", i, auto_start[i*16 +: 16], m_dly[3][i]);
			check_value("auto_increment", i, auto_increment[i*16 +: 16], m_dly[4][i]);
			check_value("auto_length", i, auto_length[i*16 +: 16], m_dly[5][i]);
		end
		check_value("current_line", 0, current_line, m_line);
		check_value("baud_rate", 0, baud_rate, m_baud);
		check_value("flags", 0, {extended, timestamp_reset, external_clock, integrating},
			{m_ext, m_ts, m_xclk, m_int});
	endtask

	// ####################
	// UART driver.
	// ####################
	task automatic drive_level(input logic v, input int n);
		@(posedge clk);
		#1 rxd = v;
		repeat (n - 1) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b);
		int period, wait_cnt, fe_before;
		period = `CORR_BAUD_UNIT * (m_baud + 1);
		fe_before = fe_count;
		wait_cnt = 0;
		drive_level(1'b0, period);
		for (int i = 0; i < 8; i++) drive_level(b[i], period);
		drive_level(1'b1, 1);
		while (!dut_i.byte_valid && wait_cnt < 3 * period) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!dut_i.byte_valid) begin
			failures++;
			$display("command %h was not received within twelve bit periods at %0t", b, $time);
		end else begin
			model_apply(b);
			repeat (2) @(posedge clk);
			check_all();
		end
		repeat (period) @(posedge clk);
		if (fe_count != fe_before) begin
			failures++;
			$display("frame_error pulsed on a good frame for command %h", b);
		end
	endtask

	task automatic send_bad_frame(input logic [7:0] b);
		int period, wait_cnt, bv_before;
		period = `CORR_BAUD_UNIT * (m_baud + 1);
		bv_before = bv_count;
		wait_cnt = 0;
		drive_level(1'b0, period);
		for (int i = 0; i < 8; i++) drive_level(b[i], period);
		drive_level(1'b0, 1);
		while (!frame_error && wait_cnt < 3 * period) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!frame_error) begin
			failures++;
			$display("a frame with a low stop bit did not raise frame_error");
		end
		drive_level(1'b1, 2 * period);
		if (bv_count != bv_before) begin
			failures++;
			$display("a frame with a low stop bit produced a byte strobe");
		end
		check_all();
	endtask

	// idle time covers a whole frame, so a wrongly accepted start would strobe in it.
	task automatic send_short_start();
		int period, bv_before, fe_before;
		period = `CORR_BAUD_UNIT * (m_baud + 1);
		bv_before = bv_count;
		fe_before = fe_count;
		drive_level(1'b0, period / 4);
		drive_level(1'b1, 12 * period);
		if (bv_count != bv_before || fe_count != fe_before) begin
			failures++;
			$display("a start pulse shorter than half a bit produced a strobe");
		end
		check_all();
	endtask

	task automatic random_cmds(input int n, input int mode);
		logic [3:0] op, nib;
		for (int i = 0; i < n; i++) begin
			op = pick_op(mode, 4'(rand_bits(4)));
			nib = 4'(rand_bits(4));
			if (op == set_baud) nib[3:2] = 2'b00;
			send_byte({nib, op});
		end
	endtask

	// ####################
	// test sequence.
	// ####################
	initial begin
		logic [3:0] nib;
		lfsr = 32'h4e608273;
		rxd = 1'b1;
		arst_n = 1'b0;
		model_reset();
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		@(posedge clk);
		check_all();
		random_cmds(40, 0);
		random_cmds(40, 1);
		random_cmds(30, 2);
		send_byte({4'h0, clear});
		for (int o = 5; o < 16; o++) begin
			nib = 4'(rand_bits(4));
			if (o < 8 || o == 11 || o >= 14) send_byte({nib, 4'(o)});
		end
		for (int sel = 0; sel < 4; sel++) begin
			send_byte({4'(sel), set_baud});
			random_cmds(5, 0);
		end
		send_bad_frame(rand_bits(8));
		send_short_start();
		send_byte({4'h0, set_baud});
		send_bad_frame(rand_bits(8));
		send_short_start();
		$display("run complete: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
